//--- source/rename_pkg.sv
package rename_pkg;

    localparam int NUM_LOGICAL = 32;
    localparam int NUM_PHYS    = 160;
    localparam int NUM_PAGES   = 8;
    localparam int FREE_DEPTH  = NUM_PHYS - NUM_LOGICAL;

    typedef logic [4:0] log_reg_t;
    typedef logic [7:0] phys_tag_t;
    typedef logic [2:0] page_t;
    typedef logic [6:0] free_ptr_t;
    typedef logic [7:0] free_cnt_t;

    // the whole alias table as one vector, entry i maps logical register i.
    typedef phys_tag_t [NUM_LOGICAL-1:0] map_table_t;

    localparam phys_tag_t TAG_NONE_SRC = 8'd254; // source not read.
    localparam phys_tag_t TAG_NONE_DST = 8'd255; // no destination written.

    // status register map of the APB slave.
    localparam logic [7:0] APB_ADDR_COUNT = 8'h00;
    localparam logic [7:0] APB_ADDR_VALID = 8'h04;
    localparam logic [7:0] APB_ADDR_TABLE = 8'h80;

    // RV32I major opcodes, the only part of the instruction decoded here.
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_e;

    typedef struct packed {
        opcode_e  opcode;
        log_reg_t rs1;
        log_reg_t rs2;
        log_reg_t rd;
    } rename_req_t;

    typedef struct packed {
        phys_tag_t ps1;
        phys_tag_t ps2;
        phys_tag_t pd;
        phys_tag_t old_pd; // freed by commit once the instruction retires.
    } rename_rsp_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

//--- source/rat_checkpoint_bank.sv
`timescale 1ns/1ns

module rat_checkpoint_bank (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               save,
    input  rename_pkg::page_t                  save_page,
    input  rename_pkg::map_table_t             save_table,
    input  rename_pkg::free_ptr_t              save_ptr,
    input  logic                               restore,
    input  rename_pkg::page_t                  restore_page,
    output rename_pkg::map_table_t             load_table,
    output rename_pkg::free_ptr_t              load_ptr,
    output logic [rename_pkg::NUM_PAGES-1:0]   page_valid
);
    import rename_pkg::*;

    map_table_t page_table [NUM_PAGES];
    free_ptr_t  page_ptr   [NUM_PAGES];

    // page contents only mean something once the valid bit is set.
    always_ff @(posedge clk) begin
        if (save) begin
            page_table[save_page] <= save_table;
            page_ptr[save_page]   <= save_ptr;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            page_valid <= '0;
        end else if (save) begin
            page_valid[save_page] <= 1'b1;
        end
    end

    // the selected page is read straight through so the table can load it
    // on the same edge that ends the restore cycle.
    always_comb begin
        load_table = page_table[restore_page];
        load_ptr   = page_ptr[restore_page];
    end

    a_restore_valid_page: assert property (
        @(posedge clk) disable iff (reset)
        restore |-> page_valid[restore_page]
    ) else $error("restore of checkpoint page %0d that was never saved", restore_page);

endmodule

//--- source/rat.sv
`timescale 1ns/1ns

module rat (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              req_valid,
    input  rename_pkg::rename_req_t           req,
    output logic                              req_ready,
    output logic                              rsp_valid,
    output rename_pkg::rename_rsp_t           rsp,
    input  rename_pkg::phys_tag_t             head_tag,
    input  logic                              empty,
    input  rename_pkg::free_ptr_t             head_ptr,
    output logic                              alloc,
    output logic                              restore_ptr_valid,
    output rename_pkg::free_ptr_t             restore_ptr,
    input  logic                              save,
    input  rename_pkg::page_t                 save_page,
    input  logic                              restore,
    input  rename_pkg::page_t                 restore_page,
    input  rename_pkg::log_reg_t              status_idx,
    output rename_pkg::phys_tag_t             status_tag,
    output logic [rename_pkg::NUM_PAGES-1:0]  page_valid
);
    import rename_pkg::*;

    map_table_t  map_q;
    map_table_t  load_table;
    rename_rsp_t rsp_d;
    logic        reads_rs1;
    logic        reads_rs2;
    logic        writes_rd;
    logic        accept;

    rat_checkpoint_bank i_checkpoint_bank (
        .clk          (clk),
        .reset        (reset),
        .save         (save),
        .save_page    (save_page),
        .save_table   (map_q),
        .save_ptr     (head_ptr),
        .restore      (restore),
        .restore_page (restore_page),
        .load_table   (load_table),
        .load_ptr     (restore_ptr),
        .page_valid   (page_valid)
    );

    // which operands each opcode actually uses.
    always_comb begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
        writes_rd = 1'b1;
        case (req.opcode)
            JALR, LOAD, OP_IMM: begin
                reads_rs2 = 1'b0;
            end
            LUI, AUIPC, JAL: begin
                reads_rs1 = 1'b0;
                reads_rs2 = 1'b0;
            end
            BRANCH, STORE: begin
                writes_rd = 1'b0;
            end
            default: begin
                writes_rd = 1'b1; // unknown opcodes are renamed like OP.
            end
        endcase
    end

    assign req_ready         = !restore && !(empty && writes_rd);
    assign accept            = req_valid && req_ready;
    assign alloc             = accept && writes_rd;
    assign restore_ptr_valid = restore;
    assign status_tag        = map_q[status_idx];

    always_comb begin
        rsp_d.ps1    = reads_rs1 ? map_q[req.rs1] : TAG_NONE_SRC;
        rsp_d.ps2    = reads_rs2 ? map_q[req.rs2] : TAG_NONE_SRC;
        rsp_d.pd     = writes_rd ? head_tag : TAG_NONE_DST;
        rsp_d.old_pd = writes_rd ? map_q[req.rd] : TAG_NONE_DST;
    end

    // x0 is renamed like any other register.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_LOGICAL; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else if (restore) begin
            map_q <= load_table;
        end else if (alloc) begin
            map_q[req.rd] <= head_tag;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp <= rsp_d;
        end
    end

    a_no_save_with_restore: assert property (
        @(posedge clk) disable iff (reset)
        !(save && restore)
    ) else $error("save and restore requested in the same cycle");

endmodule

//--- source/free_list.sv
`timescale 1ns/1ns

module free_list (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   alloc,
    output rename_pkg::phys_tag_t  head_tag,
    output rename_pkg::free_ptr_t  head_ptr,
    output logic                   empty,
    input  logic                   release_valid,
    input  rename_pkg::phys_tag_t  release_tag,
    input  logic                   restore_ptr_valid,
    input  rename_pkg::free_ptr_t  restore_ptr,
    output rename_pkg::free_cnt_t  count
);
    import rename_pkg::*;

    phys_tag_t tags [FREE_DEPTH];
    free_ptr_t tail_ptr;
    logic      head_wrap;
    logic      tail_wrap;
    logic      restore_wrap;

    // pointers carry a wrap bit so that full and empty differ in count.
    assign count    = {tail_wrap, tail_ptr} - {head_wrap, head_ptr};
    assign empty    = (count == '0);
    assign head_tag = tags[head_ptr];

    // a restore only rewinds the head, so the wrap bit of the new head follows
    // from where it lands relative to the tail.
    always_comb begin
        if (restore_ptr == head_ptr) begin
            restore_wrap = head_wrap; // nothing was taken since the save.
        end else if (restore_ptr >= tail_ptr) begin
            restore_wrap = ~tail_wrap;
        end else begin
            restore_wrap = tail_wrap;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                tags[i] <= phys_tag_t'(NUM_LOGICAL + i);
            end
            tail_ptr  <= '0;
            tail_wrap <= 1'b1; // starts full.
        end else if (release_valid) begin
            tags[tail_ptr]        <= release_tag;
            {tail_wrap, tail_ptr} <= {tail_wrap, tail_ptr} + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_ptr  <= '0;
            head_wrap <= 1'b0;
        end else if (restore_ptr_valid) begin
            head_ptr  <= restore_ptr;
            head_wrap <= restore_wrap;
        end else if (alloc) begin
            {head_wrap, head_ptr} <= {head_wrap, head_ptr} + 1'b1;
        end
    end

    a_no_release_when_full: assert property (
        @(posedge clk) disable iff (reset)
        release_valid |-> (count != free_cnt_t'(FREE_DEPTH))
    ) else $error("tag %0d released into a full free list", release_tag);

    a_no_alloc_when_empty: assert property (
        @(posedge clk) disable iff (reset)
        alloc |-> !empty
    ) else $error("allocation from an empty free list");

endmodule

//--- source/rename_apb_regs.sv
`timescale 1ns/1ns

module rename_apb_regs (
    input  rename_pkg::apb_req_t              apb_in,
    output rename_pkg::apb_rsp_t              apb_out,
    output rename_pkg::log_reg_t              status_idx,
    input  rename_pkg::phys_tag_t             status_tag,
    input  rename_pkg::free_cnt_t             count,
    input  logic [rename_pkg::NUM_PAGES-1:0]  page_valid
);
    import rename_pkg::*;

    logic        access;
    logic        is_table;
    logic        mapped;
    logic [31:0] rd_data;

    // table entries sit word-aligned from the table base upward.
    assign status_idx = apb_in.paddr[6:2];
    assign access     = apb_in.psel && apb_in.penable;
    assign is_table   = ((apb_in.paddr & APB_ADDR_TABLE) == APB_ADDR_TABLE)
                        && (apb_in.paddr[1:0] == 2'b00);

    always_comb begin
        rd_data = '0;
        mapped  = 1'b1;
        if (apb_in.paddr == APB_ADDR_COUNT) begin
            rd_data = 32'(count);
        end else if (apb_in.paddr == APB_ADDR_VALID) begin
            rd_data = 32'(page_valid);
        end else if (is_table) begin
            rd_data = 32'(status_tag);
        end else begin
            mapped = 1'b0;
        end
    end

    // no wait states, and nothing here can be written.
    always_comb begin
        apb_out.pready  = 1'b1;
        apb_out.pslverr = access && (apb_in.pwrite || !mapped);
        if (access && !apb_in.pwrite && mapped) begin
            apb_out.prdata = rd_data;
        end else begin
            apb_out.prdata = '0;
        end
    end

endmodule

//--- source/rename_top.sv
`timescale 1ns/1ns

module rename_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  rename_pkg::rename_req_t  req,
    output logic                     req_ready,
    output logic                     rsp_valid,
    output rename_pkg::rename_rsp_t  rsp,
    input  logic                     release_valid,
    input  rename_pkg::phys_tag_t    release_tag,
    input  logic                     save,
    input  rename_pkg::page_t        save_page,
    input  logic                     restore,
    input  rename_pkg::page_t        restore_page,
    input  rename_pkg::apb_req_t     apb_in,
    output rename_pkg::apb_rsp_t     apb_out
);
    import rename_pkg::*;

    phys_tag_t              head_tag;
    free_ptr_t              head_ptr;
    free_ptr_t              restore_ptr;
    free_cnt_t              count;
    log_reg_t               status_idx;
    phys_tag_t              status_tag;
    logic [NUM_PAGES-1:0]   page_valid;
    logic                   empty;
    logic                   alloc;
    logic                   restore_ptr_valid;

    rat i_rat (
        .clk               (clk),
        .reset             (reset),
        .req_valid         (req_valid),
        .req               (req),
        .req_ready         (req_ready),
        .rsp_valid         (rsp_valid),
        .rsp               (rsp),
        .head_tag          (head_tag),
        .empty             (empty),
        .head_ptr          (head_ptr),
        .alloc             (alloc),
        .restore_ptr_valid (restore_ptr_valid),
        .restore_ptr       (restore_ptr),
        .save              (save),
        .save_page         (save_page),
        .restore           (restore),
        .restore_page      (restore_page),
        .status_idx        (status_idx),
        .status_tag        (status_tag),
        .page_valid        (page_valid)
    );

    free_list i_free_list (
        .clk               (clk),
        .reset             (reset),
        .alloc             (alloc),
        .head_tag          (head_tag),
        .head_ptr          (head_ptr),
        .empty             (empty),
        .release_valid     (release_valid),
        .release_tag       (release_tag),
        .restore_ptr_valid (restore_ptr_valid),
        .restore_ptr       (restore_ptr),
        .count             (count)
    );

    rename_apb_regs i_apb_regs (
        .apb_in     (apb_in),
        .apb_out    (apb_out),
        .status_idx (status_idx),
        .status_tag (status_tag),
        .count      (count),
        .page_valid (page_valid)
    );

endmodule

//--- dv/rename_checker.sv
`timescale 1ns/1ns

module rename_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  rename_pkg::rename_req_t  req,
    input  logic                     req_ready,
    input  logic                     rsp_valid,
    input  rename_pkg::rename_rsp_t  rsp,
    input  logic                     release_valid,
    input  rename_pkg::phys_tag_t    release_tag,
    input  logic                     save,
    input  rename_pkg::page_t        save_page,
    input  logic                     restore,
    input  rename_pkg::page_t        restore_page,
    input  rename_pkg::apb_req_t     apb_in,
    input  rename_pkg::apb_rsp_t     apb_out,
    input  logic                     apb_exp_use,
    input  logic [31:0]              apb_exp
);
    import rename_pkg::*;

    phys_tag_t            model_map [NUM_LOGICAL];
    phys_tag_t            saved_map [NUM_PAGES][NUM_LOGICAL];
    int                   saved_head [NUM_PAGES];
    logic [NUM_PAGES-1:0] model_valid;
    phys_tag_t            hist [$]; // every tag ever put in the free list, oldest first.
    int                   head;
    rename_rsp_t          exp_rsp;
    logic                 pend;
    int                   error_count;

    function automatic logic writes_dest(input opcode_e op);
        return !(op == BRANCH || op == STORE);
    endfunction

    function automatic logic reads_src1(input opcode_e op);
        return !(op == LUI || op == AUIPC || op == JAL);
    endfunction

    function automatic logic reads_src2(input opcode_e op);
        return !(op == LUI || op == AUIPC || op == JAL || op == JALR || op == LOAD
                 || op == OP_IMM);
    endfunction

    function automatic int free_count();
        return hist.size() - head;
    endfunction

    task automatic expect_apb(input logic [7:0] addr, input logic wr,
                              output logic [31:0] data, output logic err);
        data = '0;
        err  = 1'b0;
        if (wr) begin
            err = 1'b1;
        end else if (addr == 8'h00) begin
            data = 32'(free_count());
        end else if (addr == 8'h04) begin
            data = 32'(model_valid);
        end else if (addr >= 8'h80 && addr[1:0] == 2'b00) begin
            data = 32'(model_map[addr[6:2]]);
        end else begin
            err = 1'b1;
        end
    endtask

    always @(posedge clk or posedge reset) begin
        logic        exp_ready;
        logic [31:0] exp_data;
        logic        exp_err;
        if (reset) begin
            for (int i = 0; i < NUM_LOGICAL; i++) begin
                model_map[i] = phys_tag_t'(i);
            end
            hist.delete();
            for (int i = NUM_LOGICAL; i < NUM_PHYS; i++) begin
                hist.push_back(phys_tag_t'(i));
            end
            head        = 0;
            model_valid = '0;
            pend        = 1'b0;
            error_count = 0;
        end else begin
            if (pend) begin
                if (!rsp_valid) begin
                    $display("A response did not arrive one cycle after its request.");
                    error_count++;
                end else if (rsp !== exp_rsp) begin
                    $display("ERR %0t: rsp expected %h got %h", $time, exp_rsp, rsp);
                    error_count++;
                end
            end else if (rsp_valid) begin
                $display("A response appeared with no request behind it.");
                error_count++;
            end
            pend = 1'b0;

            exp_ready = !restore && !(free_count() == 0 && writes_dest(req.opcode));
            if (req_ready !== exp_ready) begin
                $display("ERR %0t: req_ready expected %b got %b", $time, exp_ready, req_ready);
                error_count++;
            end

            if (apb_in.psel && apb_in.penable) begin
                if (apb_out.pready !== 1'b1) begin
                    $display("ERR %0t: pready at %h expected 1 got %b", $time,
                             apb_in.paddr, apb_out.pready);
                    error_count++;
                end
                expect_apb(apb_in.paddr, apb_in.pwrite, exp_data, exp_err);
                if (apb_out.pslverr !== exp_err) begin
                    $display("ERR %0t: pslverr at %h expected %b got %b", $time,
                             apb_in.paddr, exp_err, apb_out.pslverr);
                    error_count++;
                end else if (!exp_err && apb_out.prdata !== exp_data) begin
                    $display("ERR %0t: prdata at %h expected %0d got %0d", $time,
                             apb_in.paddr, exp_data, apb_out.prdata);
                    error_count++;
                end
                if (apb_exp_use && apb_out.prdata !== apb_exp) begin
                    $display("ERR %0t: prdata at %h differs from table value %0d, got %0d",
                             $time, apb_in.paddr, apb_exp, apb_out.prdata);
                    error_count++;
                end
            end

            // the page copy is taken from the table before this cycle's rename.
            if (save) begin
                saved_map[save_page]  = model_map;
                saved_head[save_page] = head;
                model_valid[save_page] = 1'b1;
            end
            if (restore) begin
                if (!model_valid[restore_page]) begin
                    $display("The test restored a checkpoint page that was never saved.");
                    error_count++;
                end
                model_map = saved_map[restore_page];
                head      = saved_head[restore_page];
            end
            if (req_valid && req_ready) begin
                exp_rsp.ps1    = reads_src1(req.opcode) ? model_map[req.rs1] : TAG_NONE_SRC;
                exp_rsp.ps2    = reads_src2(req.opcode) ? model_map[req.rs2] : TAG_NONE_SRC;
                exp_rsp.pd     = TAG_NONE_DST;
                exp_rsp.old_pd = TAG_NONE_DST;
                if (writes_dest(req.opcode)) begin
                    exp_rsp.pd         = hist[head];
                    exp_rsp.old_pd     = model_map[req.rd];
                    model_map[req.rd]  = hist[head];
                    head++;
                end
                pend = 1'b1;
            end
            if (release_valid) begin
                hist.push_back(release_tag);
            end
        end
    end

endmodule

//--- dv/rename_tb.sv
`timescale 1ns/1ns

module rename_tb;
    import rename_pkg::*;

    typedef enum logic [2:0] {
        K_RENAME, K_REN_REL, K_RELEASE, K_SAVE, K_RESTORE, K_APB_RD, K_APB_WR, K_DRAIN
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        opcode_e     op;
        log_reg_t    rs1;
        log_reg_t    rs2;
        log_reg_t    rd;
        logic [7:0]  arg; // release tag, page or APB address.
        logic [31:0] exp;
        logic        use_exp;
    } entry_t;

    logic        clk;
    logic        reset;
    logic        req_valid;
    rename_req_t req;
    logic        req_ready;
    logic        rsp_valid;
    rename_rsp_t rsp;
    logic        release_valid;
    phys_tag_t   release_tag;
    logic        save;
    page_t       save_page;
    logic        restore;
    page_t       restore_page;
    apb_req_t    apb_in;
    apb_rsp_t    apb_out;
    logic        apb_exp_use;
    logic [31:0] apb_exp;

    entry_t  table_q [$];
    opcode_e op_pool [9];
    int      cycles;
    int      limit;
    logic    running;

    rename_top i_rename_top (
        .clk (clk), .reset (reset),
        .req_valid (req_valid), .req (req), .req_ready (req_ready),
        .rsp_valid (rsp_valid), .rsp (rsp),
        .release_valid (release_valid), .release_tag (release_tag),
        .save (save), .save_page (save_page),
        .restore (restore), .restore_page (restore_page),
        .apb_in (apb_in), .apb_out (apb_out)
    );

    rename_checker i_checker (
        .clk (clk), .reset (reset),
        .req_valid (req_valid), .req (req), .req_ready (req_ready),
        .rsp_valid (rsp_valid), .rsp (rsp),
        .release_valid (release_valid), .release_tag (release_tag),
        .save (save), .save_page (save_page),
        .restore (restore), .restore_page (restore_page),
        .apb_in (apb_in), .apb_out (apb_out),
        .apb_exp_use (apb_exp_use), .apb_exp (apb_exp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (running) begin
            cycles++;
            if (cycles > limit) begin
                $display("Timeout after %0d cycles, the DUT stopped accepting requests.", cycles);
                $display("Test failures found");
                $finish;
            end
        end
    end

    function automatic void add_entry(input kind_e kind, input opcode_e op, input int rs1,
                                      input int rs2, input int rd, input int arg,
                                      input int exp, input logic use_exp);
        entry_t e;
        e.kind    = kind;
        e.op      = op;
        e.rs1     = log_reg_t'(rs1);
        e.rs2     = log_reg_t'(rs2);
        e.rd      = log_reg_t'(rd);
        e.arg     = 8'(arg);
        e.exp     = 32'(exp);
        e.use_exp = use_exp;
        table_q.push_back(e);
    endfunction

    function automatic void build_table();
        add_entry(K_APB_RD, OP, 0, 0, 0, 8'h00, 128, 1);
        add_entry(K_APB_RD, OP, 0, 0, 0, 8'h04, 0, 1);
        for (int i = 0; i < NUM_LOGICAL; i++) begin
            add_entry(K_APB_RD, OP, 0, 0, 0, 8'h80 + 4 * i, i, 1);
        end
        add_entry(K_RENAME, LUI, 3, 4, 1, 0, 0, 0);
        add_entry(K_RENAME, OP_IMM, 1, 9, 2, 0, 0, 0);
        add_entry(K_RENAME, OP, 1, 2, 3, 0, 0, 0);
        add_entry(K_RENAME, BRANCH, 3, 1, 5, 0, 0, 0);
        add_entry(K_RENAME, STORE, 2, 3, 6, 0, 0, 0);
        add_entry(K_RENAME, JAL, 7, 8, 1, 0, 0, 0);
        add_entry(K_RENAME, JALR, 1, 2, 4, 0, 0, 0);
        add_entry(K_RENAME, LOAD, 4, 3, 5, 0, 0, 0);
        add_entry(K_RENAME, AUIPC, 4, 3, 6, 0, 0, 0);
        add_entry(K_RENAME, OP, 5, 6, 0, 0, 0, 0);
        add_entry(K_APB_RD, OP, 0, 0, 0, 8'h00, 120, 1);
        // checkpoint, rename over it, then roll back.
        add_entry(K_SAVE, OP, 0, 0, 0, 2, 0, 0);
        add_entry(K_RENAME, OP, 5, 6, 1, 0, 0, 0);
        add_entry(K_RENAME, LUI, 0, 0, 2, 0, 0, 0);
        add_entry(K_APB_RD, OP, 0, 0, 0, 8'h04, 4, 1);
        add_entry(K_RESTORE, OP, 0, 0, 0, 2, 0, 0);
        add_entry(K_APB_RD, OP, 0, 0, 0, 8'h00, 120, 1);
        for (int i = 0; i < 7; i++) begin
            add_entry(K_APB_RD, OP, 0, 0, 0, 8'h80 + 4 * i, 0, 0);
        end
        add_entry(K_RENAME, OP, 1, 2, 8, 0, 0, 0);
        for (int i = 0; i < 60; i++) begin
            add_entry(K_RENAME, op_pool[$urandom % 9], $urandom % 32, $urandom % 32,
                      $urandom % 32, 0, 0, 0);
        end
        add_entry(K_RELEASE, OP, 0, 0, 0, 1, 0, 0);
        add_entry(K_RELEASE, OP, 0, 0, 0, 2, 0, 0);
        add_entry(K_RELEASE, OP, 0, 0, 0, 3, 0, 0);
        add_entry(K_APB_RD, OP, 0, 0, 0, 8'h00, 0, 0);
        add_entry(K_REN_REL, OP, 2, 3, 9, 4, 0, 0);
        add_entry(K_APB_RD, OP, 0, 0, 0, 8'h00, 0, 0);
        add_entry(K_DRAIN, OP, 7, 7, 7, 0, 0, 0);
        add_entry(K_RENAME, STORE, 1, 2, 3, 0, 0, 0);
        add_entry(K_RENAME, BRANCH, 4, 5, 6, 0, 0, 0);
        add_entry(K_APB_RD, OP, 0, 0, 0, 8'h00, 0, 1);
        add_entry(K_APB_RD, OP, 0, 0, 0, 8'h04, 4, 1);
        add_entry(K_RELEASE, OP, 0, 0, 0, 10, 0, 0);
        add_entry(K_RELEASE, OP, 0, 0, 0, 11, 0, 0);
        add_entry(K_RENAME, OP, 7, 8, 12, 0, 0, 0);
        add_entry(K_RENAME, OP, 12, 7, 13, 0, 0, 0);
        add_entry(K_APB_WR, OP, 0, 0, 0, 8'h00, 5, 0);
        add_entry(K_APB_RD, OP, 0, 0, 0, 8'h40, 0, 0);
        add_entry(K_APB_RD, OP, 0, 0, 0, 8'h82, 0, 0);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_entry(input entry_t e);
        logic ok;
        case (e.kind)
            K_RENAME, K_REN_REL, K_DRAIN: begin
                req_valid     = 1'b1;
                req.opcode    = e.op;
                req.rs1       = e.rs1;
                req.rs2       = e.rs2;
                req.rd        = e.rd;
                release_valid = (e.kind == K_REN_REL);
                release_tag   = e.arg;
                // a drain keeps renaming until the free list runs dry.
                do begin
                    @(negedge clk);
                    ok = req_ready;
                    next_cycle();
                    release_valid = 1'b0;
                end while (e.kind == K_DRAIN ? ok : !ok);
                req_valid = 1'b0;
            end
            K_RELEASE: begin
                release_valid = 1'b1;
                release_tag   = e.arg;
                next_cycle();
                release_valid = 1'b0;
            end
            K_SAVE: begin
                save      = 1'b1;
                save_page = page_t'(e.arg);
                next_cycle();
                save = 1'b0;
            end
            K_RESTORE: begin
                restore      = 1'b1;
                restore_page = page_t'(e.arg);
                next_cycle();
                restore = 1'b0;
            end
            default: begin
                apb_in.psel   = 1'b1;
                apb_in.pwrite = (e.kind == K_APB_WR);
                apb_in.paddr  = e.arg;
                apb_in.pwdata = e.exp;
                next_cycle();
                apb_in.penable = 1'b1;
                apb_exp_use    = e.use_exp;
                apb_exp        = e.exp;
                next_cycle();
                apb_in      = '0;
                apb_exp_use = 1'b0;
            end
        endcase
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        req_valid     = 1'b0;
        req           = '0;
        req.opcode    = OP;
        release_valid = 1'b0;
        release_tag   = '0;
        save          = 1'b0;
        save_page     = '0;
        restore       = 1'b0;
        restore_page  = '0;
        apb_in        = '0;
        apb_exp_use   = 1'b0;
        apb_exp       = '0;
        cycles        = 0;
        running       = 1'b0;
        void'($urandom(80));
        op_pool = '{LOAD, OP_IMM, AUIPC, STORE, OP, LUI, BRANCH, JALR, JAL};
        build_table();
        limit = table_q.size() * 4 + 200;
        repeat (4) @(posedge clk);
        #1;
        reset   = 1'b0;
        running = 1'b1;
        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        repeat (3) next_cycle();
        $display("rename checks done with %0d errors", i_checker.error_count);
        if (i_checker.error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- sim.f
source/rename_pkg.sv
source/rat_checkpoint_bank.sv
source/rat.sv
source/free_list.sv
source/rename_apb_regs.sv
source/rename_top.sv
dv/rename_checker.sv
dv/rename_tb.sv

//--- run_sim.sh
#!/bin/bash
# Compile and run the rename testbench with Verilator, then scan the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rename_tb \
    -f sim.f -o rename_sim > sim.log 2>&1 \
    && ./obj_dir/rename_sim >> sim.log 2>&1 \
    || { cat sim.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || exit 1
exit 0
